/* source/drbg_cmd_pkg.sv */
// DRBG command front end package with the shared widths, codes and main FSM state type.
`default_nettype none

package drbg_cmd_pkg;

  localparam int unsigned NApps         = 3;
  localparam int unsigned AppIdxWidth   = 2;
  localparam int unsigned CmdWordWidth  = 32;
  localparam int unsigned BufDepth      = 4;
  localparam int unsigned BufPtrWidth   = $clog2(BufDepth);
  localparam int unsigned MaxAdataWords = 3;
  localparam int unsigned AdataWidth    = MaxAdataWords * CmdWordWidth;
  localparam int unsigned EngineLatency = 4;

  typedef logic [CmdWordWidth-1:0] cmd_word_t;
  typedef logic [AppIdxWidth-1:0]  app_idx_t;
  typedef logic [2:0]              acmd_t;
  typedef logic [1:0]              clen_t;
  typedef logic [7:0]              glen_t;
  typedef logic [1:0]              rsp_status_t;
  typedef logic [15:0]             reseed_ctr_t;

  // Application command codes. Any other code is unsupported.
  localparam acmd_t Ins = 3'd1;
  localparam acmd_t Res = 3'd2;
  localparam acmd_t Gen = 3'd3;
  localparam acmd_t Upd = 3'd4;
  localparam acmd_t Uni = 3'd5;

  localparam rsp_status_t StatusOk         = 2'd0;
  localparam rsp_status_t StatusInvalidSeq = 2'd1;

  typedef enum logic [3:0] {
    Idle, ParseCmd, InstantPrep, InstantReq, ReseedPrep, ReseedReq, GeneratePrep,
    GenerateReq, UpdatePrep, UpdateReq, UninstantPrep, UninstantReq, ClrAData,
    CmdCompWait, Error
  } main_sm_state_e;

  // The additional-data length sits in bits 5..4 of a command header.
  function automatic clen_t hdr_clen(cmd_word_t word);
    return word[5:4];
  endfunction

endpackage

`default_nettype wire

/* source/app_cmd_arbiter.sv */
// Application command arbiter with per-port credit buffers and round-robin command grant.
`timescale 1ns/1ps
`default_nettype none

module app_cmd_arbiter #(
  parameter int unsigned NApps = drbg_cmd_pkg::NApps
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [NApps-1:0]                     app_valid_i,
  input  drbg_cmd_pkg::cmd_word_t [NApps-1:0]  app_word_i,
  input  logic                                 acmd_accept_i,
  output logic [NApps-1:0]                     app_credit_o,
  output logic                                 acmd_avail_o,
  output logic                                 xfer_valid_o,
  output drbg_cmd_pkg::cmd_word_t              xfer_word_o,
  output drbg_cmd_pkg::app_idx_t               xfer_shid_o
);
  import drbg_cmd_pkg::*;

  cmd_word_t              head_word [NApps];
  logic [BufPtrWidth:0]   need      [NApps];
  logic [NApps-1:0]       complete;
  logic [NApps-1:0]       pop;
  logic                   busy_q;
  app_idx_t               gnt_q;
  app_idx_t               last_q;
  app_idx_t               winner;
  logic [BufPtrWidth:0]   left_q;

  for (genvar i = 0; i < NApps; i++) begin : g_app
    cmd_word_t              mem_q [BufDepth];
    logic [BufPtrWidth-1:0] wr_ptr_q;
    logic [BufPtrWidth-1:0] rd_ptr_q;
    logic [BufPtrWidth:0]   cnt_q;

    // A command is complete once the header and all of its data words are buffered.
    assign head_word[i] = mem_q[rd_ptr_q];
    assign need[i]      = (BufPtrWidth+1)'(hdr_clen(head_word[i])) + (BufPtrWidth+1)'(1);
    assign complete[i]  = (cnt_q != '0) && (cnt_q >= need[i]);
    assign pop[i]       = busy_q && (gnt_q == app_idx_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (app_valid_i[i]) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop[i]) rd_ptr_q <= rd_ptr_q + 1'b1;
        case ({app_valid_i[i], pop[i]})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    // Credits guarantee space, so a write never finds the buffer full.
    always_ff @(posedge clk_i) begin
      if (app_valid_i[i]) mem_q[wr_ptr_q] <= app_word_i[i];
    end
  end

  // Search starts at the port after the last winner.
  always_comb begin
    int   idx;
    logic found;
    winner = last_q;
    found  = 1'b0;
    for (int k = 1; k <= NApps; k++) begin
      idx = (int'(last_q) + k) % NApps;
      if (!found && complete[idx]) begin
        winner = app_idx_t'(idx);
        found  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      gnt_q        <= '0;
      last_q       <= app_idx_t'(NApps - 1);
      left_q       <= '0;
      app_credit_o <= '0;
    end else begin
      app_credit_o <= pop;
      if (busy_q) begin
        left_q <= left_q - 1'b1;
        if (left_q == (BufPtrWidth+1)'(1)) busy_q <= 1'b0;
      end else if (acmd_accept_i && acmd_avail_o) begin
        busy_q <= 1'b1;
        gnt_q  <= winner;
        last_q <= winner;
        left_q <= need[winner];
      end
    end
  end

  assign acmd_avail_o = !busy_q && (|complete);
  assign xfer_valid_o = busy_q;
  assign xfer_word_o  = head_word[gnt_q];
  assign xfer_shid_o  = gnt_q;

endmodule

`default_nettype wire

/* source/cmd_parser.sv */
// Command parser that decodes the granted header and packs its additional data words.
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  xfer_valid_i,
  input  drbg_cmd_pkg::cmd_word_t               xfer_word_i,
  input  drbg_cmd_pkg::app_idx_t                xfer_shid_i,
  input  logic                                  clr_adata_i,
  output drbg_cmd_pkg::acmd_t                   acmd_o,
  output logic                                  flag0_o,
  output drbg_cmd_pkg::glen_t                   glen_o,
  output drbg_cmd_pkg::app_idx_t                shid_o,
  output logic [drbg_cmd_pkg::AdataWidth-1:0]   adata_o,
  output logic                                  acmd_eop_o
);
  import drbg_cmd_pkg::*;

  // High while additional data words of the current command are still expected.
  logic  in_data_q;
  clen_t clen_q;
  clen_t widx_q;
  logic  hdr_vld;
  logic  last_word;

  assign hdr_vld   = xfer_valid_i && !in_data_q;
  assign last_word = xfer_valid_i && in_data_q && (widx_q == clen_q - clen_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_data_q  <= 1'b0;
      clen_q     <= '0;
      widx_q     <= '0;
      acmd_eop_o <= 1'b0;
    end else begin
      acmd_eop_o <= (hdr_vld && hdr_clen(xfer_word_i) == '0) || last_word;
      if (hdr_vld) begin
        clen_q    <= hdr_clen(xfer_word_i);
        widx_q    <= '0;
        in_data_q <= (hdr_clen(xfer_word_i) != '0);
      end else if (xfer_valid_i) begin
        widx_q <= widx_q + clen_t'(1);
        if (last_word) in_data_q <= 1'b0;
      end
    end
  end

  // Header fields hold until the next header arrives.
  always_ff @(posedge clk_i) begin
    if (hdr_vld) begin
      acmd_o  <= xfer_word_i[2:0];
      flag0_o <= xfer_word_i[8];
      glen_o  <= xfer_word_i[19:12];
      shid_o  <= xfer_shid_i;
    end
    if (clr_adata_i || hdr_vld) begin
      adata_o <= '0;
    end else if (xfer_valid_i) begin
      // Data word n lands in slot n, so shorter commands leave the upper slots at zero.
      adata_o[widx_q*CmdWordWidth +: CmdWordWidth] <= xfer_word_i;
    end
  end

endmodule

`default_nettype wire

/* source/cmd_main_sm.sv */
// Main command FSM that checks command legality and sequences the entropy and engine requests.
`timescale 1ns/1ps
`default_nettype none

module cmd_main_sm #(
  parameter int unsigned NApps = drbg_cmd_pkg::NApps
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  input  logic                   acmd_avail_i,
  input  drbg_cmd_pkg::app_idx_t shid_i,
  input  drbg_cmd_pkg::acmd_t    acmd_i,
  input  logic                   acmd_eop_i,
  input  logic                   engine_rdy_i,
  input  logic                   flag0_i,
  input  logic                   entropy_avail_i,
  input  logic                   cmd_complete_i,
  input  logic                   local_escalate_i,
  output logic                   acmd_accept_o,
  output logic                   entropy_req_o,
  output logic                   instant_req_o,
  output logic                   reseed_req_o,
  output logic                   generate_req_o,
  output logic                   update_req_o,
  output logic                   uninstant_req_o,
  output logic                   clr_adata_o,
  output logic                   invalid_cmd_seq_o,
  output logic                   alert_o,
  output logic                   err_o
);
  import drbg_cmd_pkg::*;

  main_sm_state_e   state_d, state_q;
  // One bit per instance records whether it is instantiated.
  logic [NApps-1:0] instantiated_d, instantiated_q;
  logic             inst_hit;

  assign inst_hit = instantiated_q[shid_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= Idle;
      instantiated_q <= '0;
    end else begin
      state_q        <= state_d;
      instantiated_q <= instantiated_d;
    end
  end

  always_comb begin
    state_d           = state_q;
    instantiated_d    = instantiated_q;
    acmd_accept_o     = 1'b0;
    entropy_req_o     = 1'b0;
    instant_req_o     = 1'b0;
    reseed_req_o      = 1'b0;
    generate_req_o    = 1'b0;
    update_req_o      = 1'b0;
    uninstant_req_o   = 1'b0;
    clr_adata_o       = 1'b0;
    invalid_cmd_seq_o = 1'b0;
    alert_o           = 1'b0;
    err_o             = 1'b0;

    if (state_q == Error) begin
      // Only reset leaves the error state.
      err_o = 1'b1;
    end else if (local_escalate_i) begin
      state_d = Error;
    end else if (!enable_i) begin
      state_d        = Idle;
      instantiated_d = '0;
    end else begin
      case (state_q)
        Idle: begin
          if (engine_rdy_i && acmd_avail_i) begin
            acmd_accept_o = 1'b1;
            state_d       = ParseCmd;
          end
        end
        ParseCmd: begin
          // Header fields are only trusted once the whole command has arrived.
          if (acmd_eop_i) begin
            state_d = Idle;
            case (acmd_i)
              Ins: begin
                if (inst_hit) begin
                  invalid_cmd_seq_o = 1'b1;
                end else begin
                  instantiated_d[shid_i] = 1'b1;
                  state_d                = InstantPrep;
                end
              end
              Res, Gen, Upd: begin
                if (!inst_hit) invalid_cmd_seq_o = 1'b1;
                else if (acmd_i == Res) state_d = ReseedPrep;
                else if (acmd_i == Gen) state_d = GeneratePrep;
                else state_d = UpdatePrep;
              end
              Uni: begin
                instantiated_d[shid_i] = 1'b0;
                state_d                = UninstantPrep;
              end
              default: alert_o = 1'b1;
            endcase
          end
        end
        InstantPrep, ReseedPrep: begin
          // Without flag0 the command waits for fresh entropy.
          entropy_req_o = !flag0_i;
          if (flag0_i || entropy_avail_i) begin
            state_d = (state_q == InstantPrep) ? InstantReq : ReseedReq;
          end
        end
        GeneratePrep:  state_d = GenerateReq;
        UpdatePrep:    state_d = UpdateReq;
        UninstantPrep: state_d = UninstantReq;
        InstantReq: begin
          instant_req_o = 1'b1;
          state_d       = ClrAData;
        end
        ReseedReq: begin
          reseed_req_o = 1'b1;
          state_d      = ClrAData;
        end
        GenerateReq: begin
          generate_req_o = 1'b1;
          state_d        = ClrAData;
        end
        UpdateReq: begin
          update_req_o = 1'b1;
          state_d      = ClrAData;
        end
        UninstantReq: begin
          uninstant_req_o = 1'b1;
          state_d         = ClrAData;
        end
        ClrAData: begin
          clr_adata_o = 1'b1;
          state_d     = CmdCompWait;
        end
        CmdCompWait: begin
          if (cmd_complete_i) state_d = Idle;
        end
        default: begin
          state_d = Error;
          err_o   = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/drbg_cmd_engine.sv */
// DRBG command engine with fixed latency and per-instance reseed counter bookkeeping.
`timescale 1ns/1ps
`default_nettype none

module drbg_cmd_engine (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        instant_req_i,
  input  logic                        reseed_req_i,
  input  logic                        generate_req_i,
  input  logic                        update_req_i,
  input  logic                        uninstant_req_i,
  input  logic                        invalid_cmd_seq_i,
  input  drbg_cmd_pkg::acmd_t         acmd_i,
  input  drbg_cmd_pkg::app_idx_t      shid_i,
  input  drbg_cmd_pkg::glen_t         glen_i,
  output logic                        engine_rdy_o,
  output logic                        cmd_complete_o,
  output logic                        rsp_valid_o,
  output drbg_cmd_pkg::app_idx_t      rsp_shid_o,
  output drbg_cmd_pkg::acmd_t         rsp_acmd_o,
  output drbg_cmd_pkg::rsp_status_t   rsp_status_o,
  output drbg_cmd_pkg::reseed_ctr_t   rsp_reseed_ctr_o
);
  import drbg_cmd_pkg::*;

  logic                             start;
  logic                             fire;
  logic                             busy_q;
  logic [$clog2(EngineLatency)-1:0] lat_cnt_q;
  acmd_t                            cmd_q;
  app_idx_t                         shid_q;
  reseed_ctr_t                      reseed_ctr_q [NApps];
  reseed_ctr_t                      ctr_next;

  assign start = instant_req_i | reseed_req_i | generate_req_i | update_req_i | uninstant_req_i;
  // The response register loads one cycle before the latency expires.
  assign fire  = busy_q && (lat_cnt_q == 1);

  // A new request is only taken while no command is in flight.
  assign engine_rdy_o = !busy_q;

  always_comb begin
    ctr_next = reseed_ctr_q[shid_q];
    case (cmd_q)
      Ins, Res, Uni: ctr_next = '0;
      Gen:           ctr_next = reseed_ctr_q[shid_q] + reseed_ctr_t'(1);
      default:       ctr_next = reseed_ctr_q[shid_q];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q         <= 1'b0;
      lat_cnt_q      <= '0;
      rsp_valid_o    <= 1'b0;
      cmd_complete_o <= 1'b0;
      reseed_ctr_q   <= '{default: '0};
    end else begin
      rsp_valid_o    <= fire | invalid_cmd_seq_i;
      cmd_complete_o <= fire;
      if (start) begin
        busy_q    <= 1'b1;
        lat_cnt_q <= ($clog2(EngineLatency))'(EngineLatency - 1);
      end else if (busy_q) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
        if (fire) begin
          busy_q               <= 1'b0;
          reseed_ctr_q[shid_q] <= ctr_next;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      cmd_q  <= acmd_i;
      shid_q <= shid_i;
    end
    if (invalid_cmd_seq_i) begin
      rsp_shid_o       <= shid_i;
      rsp_acmd_o       <= acmd_i;
      rsp_status_o     <= StatusInvalidSeq;
      rsp_reseed_ctr_o <= reseed_ctr_q[shid_i];
    end else if (fire) begin
      rsp_shid_o       <= shid_q;
      rsp_acmd_o       <= cmd_q;
      rsp_status_o     <= StatusOk;
      rsp_reseed_ctr_o <= ctr_next;
    end
  end

endmodule

`default_nettype wire

/* source/drbg_cmd_top.sv */
// DRBG command front end top level joining the arbiter, parser, main FSM and engine.
`timescale 1ns/1ps
`default_nettype none

module drbg_cmd_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              enable_i,
  input  logic [drbg_cmd_pkg::NApps-1:0]                    app_valid_i,
  input  drbg_cmd_pkg::cmd_word_t [drbg_cmd_pkg::NApps-1:0] app_word_i,
  input  logic                                              entropy_avail_i,
  input  logic                                              local_escalate_i,
  output logic [drbg_cmd_pkg::NApps-1:0]                    app_credit_o,
  output logic                                              entropy_req_o,
  output logic                                              rsp_valid_o,
  output drbg_cmd_pkg::app_idx_t                            rsp_shid_o,
  output drbg_cmd_pkg::acmd_t                               rsp_acmd_o,
  output drbg_cmd_pkg::rsp_status_t                         rsp_status_o,
  output drbg_cmd_pkg::reseed_ctr_t                         rsp_reseed_ctr_o,
  output logic                                              alert_o,
  output logic                                              err_o
);
  import drbg_cmd_pkg::*;

  logic                  acmd_avail, acmd_accept, acmd_eop;
  logic                  xfer_valid;
  cmd_word_t             xfer_word;
  app_idx_t              xfer_shid, shid;
  acmd_t                 acmd;
  logic                  flag0, clr_adata;
  glen_t                 glen;
  logic [AdataWidth-1:0] adata;
  logic                  instant_req, reseed_req, generate_req, update_req, uninstant_req;
  logic                  invalid_cmd_seq, engine_rdy, cmd_complete;

  app_cmd_arbiter #(.NApps(NApps)) u_arbiter (
    .clk_i, .rst_ni, .app_valid_i, .app_word_i,
    .acmd_accept_i (acmd_accept), .app_credit_o, .acmd_avail_o (acmd_avail),
    .xfer_valid_o (xfer_valid), .xfer_word_o (xfer_word), .xfer_shid_o (xfer_shid)
  );

  // The packed additional data has no consumer yet since the engine models no cryptography.
  cmd_parser u_parser (
    .clk_i, .rst_ni, .xfer_valid_i (xfer_valid), .xfer_word_i (xfer_word),
    .xfer_shid_i (xfer_shid), .clr_adata_i (clr_adata), .acmd_o (acmd), .flag0_o (flag0),
    .glen_o (glen), .shid_o (shid), .adata_o (adata), .acmd_eop_o (acmd_eop)
  );

  cmd_main_sm #(.NApps(NApps)) u_main_sm (
    .clk_i, .rst_ni, .enable_i, .acmd_avail_i (acmd_avail), .shid_i (shid), .acmd_i (acmd),
    .acmd_eop_i (acmd_eop), .engine_rdy_i (engine_rdy), .flag0_i (flag0), .entropy_avail_i,
    .cmd_complete_i (cmd_complete), .local_escalate_i, .acmd_accept_o (acmd_accept),
    .entropy_req_o, .instant_req_o (instant_req), .reseed_req_o (reseed_req),
    .generate_req_o (generate_req), .update_req_o (update_req),
    .uninstant_req_o (uninstant_req), .clr_adata_o (clr_adata),
    .invalid_cmd_seq_o (invalid_cmd_seq), .alert_o, .err_o
  );

  drbg_cmd_engine u_engine (
    .clk_i, .rst_ni, .instant_req_i (instant_req), .reseed_req_i (reseed_req),
    .generate_req_i (generate_req), .update_req_i (update_req),
    .uninstant_req_i (uninstant_req), .invalid_cmd_seq_i (invalid_cmd_seq),
    .acmd_i (acmd), .shid_i (shid), .glen_i (glen), .engine_rdy_o (engine_rdy),
    .cmd_complete_o (cmd_complete), .rsp_valid_o, .rsp_shid_o, .rsp_acmd_o, .rsp_status_o,
    .rsp_reseed_ctr_o
  );

endmodule

`default_nettype wire

/* test/tb_drbg_cmd_tasks.svh */
// Directed tests for the DRBG command front end with the command send and value check tasks.

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Fail %s: %s expected %0h actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  // Header layout is acmd in 2..0, clen in 5..4, flag0 in 8 and glen in 19..12.
  function automatic cmd_word_t make_hdr(acmd_t cmd, clen_t clen, logic flag0, glen_t glen);
    cmd_word_t hdr;
    hdr        = '0;
    hdr[2:0]   = cmd;
    hdr[5:4]   = clen;
    hdr[8]     = flag0;
    hdr[19:12] = glen;
    return hdr;
  endfunction

  // Applies the command rules to the model and queues the response the DUT owes.
  task automatic expect_cmd(input int app, input acmd_t cmd);
    exp_rsp_t rsp;
    logic     legal;
    legal = 1'b1;
    if (cmd == Ins) legal = !model_inst[app];
    if (cmd == Res || cmd == Gen || cmd == Upd) legal = model_inst[app];
    if (!legal) begin
      rsp.status = StatusInvalidSeq;
    end else begin
      rsp.status = StatusOk;
      if (cmd == Ins) model_inst[app] = 1'b1;
      if (cmd == Uni) model_inst[app] = 1'b0;
      if (cmd == Gen) model_ctr[app] = model_ctr[app] + 1'b1;
      else if (cmd != Upd) model_ctr[app] = '0;
    end
    rsp.shid = app_idx_t'(app);
    rsp.acmd = cmd;
    rsp.ctr  = model_ctr[app];
    rr_last  = app;
    exp_q.push_back(rsp);
  endtask

  // Sends a header and clen random data words, holding each word until a credit is free.
  task automatic send_cmd(input int app, input acmd_t cmd, input int clen, input logic flag0);
    cmd_word_t word;
    @(posedge clk_i);
    for (int n = 0; n <= clen; n++) begin
      if (n == 0) word = make_hdr(cmd, clen_t'(clen), flag0, glen_t'($random(seed)));
      else word = $random(seed);
      while (sent[app] - returned[app] >= BufDepth) begin
        app_valid_i[app] <= 1'b0;
        @(posedge clk_i);
      end
      app_valid_i[app] <= 1'b1;
      app_word_i[app]  <= word;
      sent[app]++;
      @(posedge clk_i);
    end
    app_valid_i[app] <= 1'b0;
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic run_cmd(input int app, input acmd_t cmd, input int clen, input logic flag0);
    expect_cmd(app, cmd);
    send_cmd(app, cmd, clen, flag0);
    wait_responses();
  endtask

  task automatic check_credits();
    for (int a = 0; a < NApps; a++) begin
      check_value($sformatf("credits returned to application %0d", a), sent[a], returned[a]);
    end
  endtask

  task automatic idle_after_reset();
    test_name = "reset_state";
    repeat (10) begin
      @(posedge clk_i);
      check_value("app_credit_o", '0, app_credit_o);
      check_value("rsp_valid_o", 0, rsp_valid_o);
      check_value("entropy_req_o", 0, entropy_req_o);
      check_value("alert_o", 0, alert_o);
      check_value("err_o", 0, err_o);
    end
  endtask

  task automatic generate_sequence();
    test_name = "generate_sequence";
    run_cmd(0, Ins, 0, 1'b1);
    run_cmd(0, Gen, 1, 1'b0);
    run_cmd(0, Gen, 2, 1'b0);
    run_cmd(0, Gen, 3, 1'b0);
    run_cmd(0, Upd, 1, 1'b0);
    run_cmd(0, Res, 0, 1'b1);
    check_credits();
  endtask

  task automatic illegal_sequence();
    test_name = "illegal_sequence";
    run_cmd(2, Gen, 0, 1'b0);
    run_cmd(0, Gen, 1, 1'b0);
    // A second instantiate must report the counter left by the generate above.
    run_cmd(0, Ins, 0, 1'b1);
    run_cmd(0, Uni, 0, 1'b0);
    run_cmd(0, Gen, 2, 1'b0);
    check_credits();
  endtask

  task automatic entropy_wait();
    test_name = "entropy_wait";
    expect_cmd(1, Ins);
    send_cmd(1, Ins, 1, 1'b0);
    while (!entropy_req_o) @(posedge clk_i);
    repeat (20) begin
      @(posedge clk_i);
      check_value("rsp_valid_o without entropy", 0, rsp_valid_o);
      check_value("entropy_req_o held", 1, entropy_req_o);
    end
    entropy_avail_i <= 1'b1;
    @(posedge clk_i);
    entropy_avail_i <= 1'b0;
    wait_responses();
    check_value("entropy_req_o after entropy", 0, entropy_req_o);
    check_credits();
  endtask

  task automatic multi_app_arbitration();
    acmd_t cmds [NApps];
    int    first;
    test_name = "multi_app";
    cmds[0] = Ins;
    cmds[1] = Gen;
    cmds[2] = Ins;
    // All three commands complete in the same cycle, so grants follow the last winner.
    first = rr_last;
    for (int k = 1; k <= NApps; k++) begin
      expect_cmd((first + k) % NApps, cmds[(first + k) % NApps]);
    end
    fork
      send_cmd(0, cmds[0], 1, 1'b1);
      send_cmd(1, cmds[1], 1, 1'b1);
      send_cmd(2, cmds[2], 1, 1'b1);
    join
    wait_responses();
    check_value("alerts before unsupported code", 0, alert_cnt);
    send_cmd(2, acmd_t'(7), 0, 1'b0);
    rr_last = 2;
    while (alert_cnt == 0) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    check_value("alerts after unsupported code", 1, alert_cnt);
    enable_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    enable_i   <= 1'b1;
    model_inst = '0;
    run_cmd(1, Gen, 0, 1'b0);
    check_credits();
  endtask

  task automatic escalation_lock();
    test_name = "escalation";
    check_value("err_o before escalation", 0, err_o);
    @(posedge clk_i);
    local_escalate_i <= 1'b1;
    @(posedge clk_i);
    local_escalate_i <= 1'b0;
    repeat (10) begin
      @(posedge clk_i);
      check_value("err_o after escalation", 1, err_o);
    end
    // Instance 2 would answer this generate if the FSM were still running.
    send_cmd(2, Gen, 0, 1'b0);
    repeat (50) begin
      @(posedge clk_i);
      check_value("err_o held", 1, err_o);
    end
  endtask

/* test/tb_drbg_cmd.sv */
// Testbench for the DRBG command front end with reference model, response monitor and timeout.
`timescale 1ns/1ps
`default_nettype none

module tb_drbg_cmd;
  import drbg_cmd_pkg::*;

  // About three times the length of the whole test sequence.
  localparam int unsigned TimeoutCycles = 3000;

  typedef struct packed {
    app_idx_t    shid;
    acmd_t       acmd;
    rsp_status_t status;
    reseed_ctr_t ctr;
  } exp_rsp_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  enable_i;
  logic [NApps-1:0]      app_valid_i;
  cmd_word_t [NApps-1:0] app_word_i;
  logic                  entropy_avail_i;
  logic                  local_escalate_i;
  logic [NApps-1:0]      app_credit_o;
  logic                  entropy_req_o;
  logic                  rsp_valid_o;
  app_idx_t              rsp_shid_o;
  acmd_t                 rsp_acmd_o;
  rsp_status_t           rsp_status_o;
  reseed_ctr_t           rsp_reseed_ctr_o;
  logic                  alert_o;
  logic                  err_o;

  integer   seed      = 65964;
  string    test_name = "reset";
  int       error_cnt = 0;
  int       cycle_cnt = 0;
  int       alert_cnt = 0;
  int       sent      [NApps];
  int       returned  [NApps];
  exp_rsp_t exp_q     [$];

  // Reference model of instantiation state, reseed counters and the last arbiter winner.
  logic [NApps-1:0] model_inst;
  reseed_ctr_t      model_ctr [NApps];
  int               rr_last;

  always #5 clk_i = ~clk_i;

  drbg_cmd_top u_dut (
    .clk_i, .rst_ni, .enable_i, .app_valid_i, .app_word_i, .entropy_avail_i,
    .local_escalate_i, .app_credit_o, .entropy_req_o, .rsp_valid_o, .rsp_shid_o,
    .rsp_acmd_o, .rsp_status_o, .rsp_reseed_ctr_o, .alert_o, .err_o
  );

  task automatic abort_run(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  `include "tb_drbg_cmd_tasks.svh"

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run("The run exceeded its cycle limit before all tests finished");
    end
  end

  // Responses must arrive in the same order as the model queued them.
  always @(posedge clk_i) begin
    exp_rsp_t want;
    if (rst_ni && alert_o) alert_cnt++;
    if (rst_ni && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("A response for instance %0d arrived in test %s with none expected",
                            rsp_shid_o, test_name));
      end else begin
        want = exp_q.pop_front();
        check_value("response shid", want.shid, rsp_shid_o);
        check_value("response acmd", want.acmd, rsp_acmd_o);
        check_value("response status", want.status, rsp_status_o);
        check_value("response reseed counter", want.ctr, rsp_reseed_ctr_o);
      end
    end
  end

  // Credit pulses are counted at the falling edge, half a cycle after they rise.
  always @(negedge clk_i) begin
    for (int a = 0; a < NApps; a++) begin
      if (rst_ni && app_credit_o[a]) begin
        returned[a]++;
        if (returned[a] > sent[a]) begin
          abort_run($sformatf("Application %0d got back more credits than it sent words", a));
        end
      end
    end
  end

  initial begin
    rst_ni           = 1'b0;
    enable_i         = 1'b1;
    app_valid_i      = '0;
    app_word_i       = '0;
    entropy_avail_i  = 1'b0;
    local_escalate_i = 1'b0;
    model_inst       = '0;
    rr_last          = NApps - 1;
    for (int a = 0; a < NApps; a++) begin
      sent[a]      = 0;
      returned[a]  = 0;
      model_ctr[a] = '0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle_after_reset();
    generate_sequence();
    illegal_sequence();
    entropy_wait();
    multi_app_arbitration();
    escalation_lock();
    if (error_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
source/drbg_cmd_pkg.sv
source/app_cmd_arbiter.sv
source/cmd_parser.sv
source/cmd_main_sm.sv
source/drbg_cmd_engine.sv
source/drbg_cmd_top.sv
test/tb_drbg_cmd.sv
